/* hw/misc_alu.sv */
`timescale 1ns/1ps

module misc_alu
	import misc_alu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,

	input  logic     req_valid,
	output logic     req_ready,
	input  misc_op_t op,
	input  dest_t    dest,
	input  logic     sat_disable,
	input  shamt_t   shamt,
	input  data_t    a,
	input  data_t    b,
	input  data_t    c,
	input  acc_t     acc,

	output logic     rsp_valid,
	input  logic     rsp_ready,
	output dest_t    rsp_dest,
	output acc_t     result
);

	req_t  req_bus;
	prep_t prep_d;
	prep_t prep_q;
	fin_t  fin_d;
	fin_t  fin_q;
	rsp_t  rsp_d;
	rsp_t  rsp_q;

	logic  prep_valid;
	logic  finish_ready;
	logic  fin_valid;
	logic  rsp_in_ready;

	assign req_bus = '{
		op:          op,
		dest:        dest,
		sat_disable: sat_disable,
		shamt:       shamt,
		a:           a,
		b:           b,
		c:           c,
		acc:         acc
	};

	misc_prep u_misc_prep (
		.req  (req_bus),
		.prep (prep_d)
	);

	pipe_slice #(.payload_t(prep_t)) slice_prep (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (prep_d),
		.out_valid (prep_valid),
		.out_ready (finish_ready),
		.out_data  (prep_q)
	);

	misc_finish u_misc_finish (
		.prep (prep_q),
		.fin  (fin_d)
	);

	pipe_slice #(.payload_t(fin_t)) slice_finish (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (prep_valid),
		.in_ready  (finish_ready),
		.in_data   (fin_d),
		.out_valid (fin_valid),
		.out_ready (rsp_in_ready),
		.out_data  (fin_q)
	);

	misc_select u_misc_select (
		.fin (fin_q),
		.rsp (rsp_d)
	);

	// last slice faces the consumer directly.
	pipe_slice #(.payload_t(rsp_t)) slice_rsp (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (fin_valid),
		.in_ready  (rsp_in_ready),
		.in_data   (rsp_d),
		.out_valid (rsp_valid),
		.out_ready (rsp_ready),
		.out_data  (rsp_q)
	);

	assign rsp_dest = rsp_q.dest;
	assign result   = rsp_q.result;

endmodule

/* hw/misc_alu_cfg.svh */
`ifndef MISC_ALU_CFG_SVH
`define MISC_ALU_CFG_SVH

`define MISC_DATA_WIDTH  16
`define MISC_GUARD_WIDTH 8
`define MISC_ACC_WIDTH   (2 * `MISC_DATA_WIDTH + `MISC_GUARD_WIDTH)

`define MISC_DEST_WIDTH  4
`define MISC_SHAMT_WIDTH 4

// codes 9 to 15 decode to a zero result.
`define MISC_OP_WIDTH    4

`endif

/* hw/misc_alu_pkg.sv */
`include "misc_alu_cfg.svh"

package misc_alu_pkg;

	typedef logic signed [`MISC_DATA_WIDTH - 1 : 0] data_t;
	typedef logic signed [`MISC_ACC_WIDTH - 1 : 0]  acc_t;
	typedef logic [`MISC_DEST_WIDTH - 1 : 0]        dest_t;
	typedef logic [`MISC_SHAMT_WIDTH - 1 : 0]       shamt_t;

	typedef enum logic [`MISC_OP_WIDTH - 1 : 0] {
		op_lsh      = 4'd0,
		op_rsh      = 4'd1,
		op_abs      = 4'd2,
		op_min      = 4'd3,
		op_max      = 4'd4,
		op_clamp    = 4'd5,
		op_mov_acc  = 4'd6, // acc >>> 15.
		op_mov_uacc = 4'd7, // acc[31:16].
		op_mov_lacc = 4'd8  // acc[15:0].
	} misc_op_t;

	typedef struct packed {
		misc_op_t op;
		dest_t    dest;
		logic     sat_disable;
		shamt_t   shamt;
		data_t    a;
		data_t    b;
		data_t    c;
		acc_t     acc;
	} req_t;

	// after the coarse shifts by 8 and 4.
	typedef struct packed {
		misc_op_t   op;
		dest_t      dest;
		logic       sat_disable;
		logic [1:0] shamt_lo;
		data_t      a;
		data_t      lsh;
		data_t      rsh;
		data_t      abs;
		data_t      min;
		data_t      max;
		data_t      lo; // lower clamp bound.
		data_t      hi;
		acc_t       acc_shift;
		data_t      upper;
		data_t      lower;
	} prep_t;

	typedef struct packed {
		misc_op_t op;
		dest_t    dest;
		logic     sat_disable;
		data_t    lsh;
		data_t    rsh;
		data_t    abs;
		data_t    min;
		data_t    max;
		data_t    clamp;
		acc_t     acc_shift;
		data_t    upper;
		data_t    lower;
	} fin_t;

	typedef struct packed {
		dest_t dest;
		acc_t  result;
	} rsp_t;

endpackage

/* hw/misc_finish.sv */
`timescale 1ns/1ps

module misc_finish
	import misc_alu_pkg::*;
(
	input  prep_t prep,
	output fin_t  fin
);

	data_t lsh_2;
	data_t lsh_1;
	data_t rsh_2;
	data_t rsh_1;
	logic  below_lo;
	logic  above_hi;
	data_t clamp_val;

	// fine half of the shifter.
	assign lsh_2 = prep.shamt_lo[1] ? (prep.lsh << 2) : prep.lsh;
	assign lsh_1 = prep.shamt_lo[0] ? (lsh_2 << 1) : lsh_2;

	assign rsh_2 = prep.shamt_lo[1] ? (prep.rsh >> 2) : prep.rsh;
	assign rsh_1 = prep.shamt_lo[0] ? (rsh_2 >> 1) : rsh_2;

	assign below_lo = prep.a < prep.lo;
	assign above_hi = prep.a > prep.hi;

	// lo <= hi holds from stage one.
	always_comb begin
		if (below_lo) begin
			clamp_val = prep.lo;
		end else if (above_hi) begin
			clamp_val = prep.hi;
		end else begin
			clamp_val = prep.a;
		end
	end

	always_comb begin
		fin.op          = prep.op;
		fin.dest        = prep.dest;
		fin.sat_disable = prep.sat_disable;

		fin.lsh   = lsh_1;
		fin.rsh   = rsh_1;
		fin.abs   = prep.abs;
		fin.min   = prep.min;
		fin.max   = prep.max;
		fin.clamp = clamp_val;

		fin.acc_shift = prep.acc_shift;
		fin.upper     = prep.upper;
		fin.lower     = prep.lower;
	end

endmodule

/* hw/misc_prep.sv */
`timescale 1ns/1ps
`include "misc_alu_cfg.svh"

module misc_prep
	import misc_alu_pkg::*;
(
	input  req_t  req,
	output prep_t prep
);

	localparam int acc_frac = `MISC_DATA_WIDTH - 1;

	data_t lsh_8;
	data_t lsh_4;
	data_t rsh_8;
	data_t rsh_4;
	data_t abs_a;
	data_t min_ab;
	data_t max_ab;
	logic  clamp_swap;
	data_t clamp_lo;
	data_t clamp_hi;
	acc_t  acc_shift;

	// coarse half of the barrel shifter.
	assign lsh_8 = req.shamt[3] ? (req.a << 8) : req.a;
	assign lsh_4 = req.shamt[2] ? (lsh_8 << 4) : lsh_8;

	// logical, zero fill.
	assign rsh_8 = req.shamt[3] ? (req.a >> 8) : req.a;
	assign rsh_4 = req.shamt[2] ? (rsh_8 >> 4) : rsh_8;

	// -32768 wraps to itself.
	assign abs_a = req.a[`MISC_DATA_WIDTH - 1] ? -req.a : req.a;

	assign min_ab = (req.a < req.b) ? req.a : req.b;
	assign max_ab = (req.a > req.b) ? req.a : req.b;

	// bounds may arrive in either order.
	assign clamp_swap = req.c < req.b;
	assign clamp_lo   = clamp_swap ? req.c : req.b;
	assign clamp_hi   = clamp_swap ? req.b : req.c;

	assign acc_shift = req.acc >>> acc_frac;

	always_comb begin
		prep.op          = req.op;
		prep.dest        = req.dest;
		prep.sat_disable = req.sat_disable;
		prep.shamt_lo    = req.shamt[1:0];

		prep.a   = req.a;
		prep.lsh = lsh_4;
		prep.rsh = rsh_4;

		prep.abs = abs_a;
		prep.min = min_ab;
		prep.max = max_ab;

		prep.lo = clamp_lo;
		prep.hi = clamp_hi;

		prep.acc_shift = acc_shift;
		prep.upper     = req.acc[2 * `MISC_DATA_WIDTH - 1 : `MISC_DATA_WIDTH];
		prep.lower     = req.acc[`MISC_DATA_WIDTH - 1 : 0];
	end

endmodule

/* hw/misc_select.sv */
`timescale 1ns/1ps
`include "misc_alu_cfg.svh"

module misc_select
	import misc_alu_pkg::*;
(
	input  fin_t fin,
	output rsp_t rsp
);

	localparam acc_t sat_max = 2 ** (`MISC_DATA_WIDTH - 1) - 1;
	localparam acc_t sat_min = -(2 ** (`MISC_DATA_WIDTH - 1));

	acc_t sel;
	acc_t sel_sat;

	function automatic acc_t sext(data_t v);
		return {{(`MISC_ACC_WIDTH - `MISC_DATA_WIDTH){v[`MISC_DATA_WIDTH - 1]}}, v};
	endfunction

	always_comb begin
		case (fin.op)
			op_lsh:      sel = sext(fin.lsh);
			op_rsh:      sel = sext(fin.rsh);
			op_abs:      sel = sext(fin.abs);
			op_min:      sel = sext(fin.min);
			op_max:      sel = sext(fin.max);
			op_clamp:    sel = sext(fin.clamp);
			op_mov_acc:  sel = fin.acc_shift; // only op that can leave 16-bit range.
			op_mov_uacc: sel = sext(fin.upper);
			op_mov_lacc: sel = sext(fin.lower);
			default:     sel = '0; // unused codes.
		endcase
	end

	always_comb begin
		if (sel > sat_max) begin
			sel_sat = sat_max;
		end else if (sel < sat_min) begin
			sel_sat = sat_min;
		end else begin
			sel_sat = sel;
		end
	end

	always_comb begin
		rsp.dest   = fin.dest;
		rsp.result = fin.sat_disable ? sel : sel_sat;
	end

endmodule

/* hw/pipe_slice.sv */
`timescale 1ns/1ps

module pipe_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,

	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic take_in;
	logic take_out;

	// full slice still advances when downstream takes.
	assign in_ready = ~out_valid | out_ready;

	assign take_in  = in_valid & in_ready;
	assign take_out = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (take_in) begin
			out_valid <= 1'b1;
		end else if (take_out) begin
			out_valid <= 1'b0; // drained.
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out_data <= in_data;
		end
	end

endmodule

/* project.f */
+incdir+hw
hw/misc_alu_pkg.sv
hw/pipe_slice.sv
hw/misc_prep.sv
hw/misc_finish.sv
hw/misc_select.sv
hw/misc_alu.sv
tests/misc_alu_checker.sv
tests/misc_alu_assert.sv
tests/misc_alu_tb.sv

/* tests/misc_alu_assert.sv */
`timescale 1ns/1ps

module misc_alu_assert
	import misc_alu_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  rsp_valid,
	input logic  rsp_ready,
	input dest_t rsp_dest,
	input acc_t  result
);

	int fail_count = 0;

	rsp_hold: assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_dest) && $stable(result))
	else begin
		fail_count++; // stalled output must not move.
		$error("rsp_valid dropped or its payload changed while rsp_ready was low");
	end

	rsp_reset: assert property (@(posedge clk) reset |=> !rsp_valid)
	else begin
		fail_count++;
		$error("rsp_valid was high in the cycle after reset");
	end

endmodule

bind misc_alu misc_alu_assert u_misc_alu_assert (
	.clk       (clk),
	.reset     (reset),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_dest  (rsp_dest),
	.result    (result)
);

/* tests/misc_alu_checker.sv */
`timescale 1ns/1ps

module misc_alu_checker
	import misc_alu_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  req_valid,
	input logic  req_ready,
	input logic  rsp_valid,
	input logic  rsp_ready,
	input dest_t rsp_dest,
	input acc_t  result,
	input logic  check_latency
);

	rsp_t exp_q[$];
	int   accept_q[$]; // cycle of each accepted request.
	int   cycle = 0;
	int   error_count = 0;
	int   checked_count = 0;

	function automatic void expect_rsp(dest_t d, acc_t r);
		rsp_t e;
		e.dest   = d;
		e.result = r;
		exp_q.push_back(e);
	endfunction

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	always @(posedge clk) begin : compare
		rsp_t e;
		int   t0;
		if (reset) begin
			cycle = 0;
			accept_q.delete();
		end else begin
			if (req_valid && req_ready) begin
				accept_q.push_back(cycle);
			end
			if (check_latency && req_valid && !req_ready) begin
				error_count++;
				$display("Fail at %0t: req_ready expected 1 got %b", $time, req_ready);
			end
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0 || accept_q.size() == 0) begin
					error_count++;
					$display("response with tag %0d at %0t was never requested", rsp_dest, $time);
				end else begin
					e  = exp_q.pop_front();
					t0 = accept_q.pop_front();
					checked_count++;
					if (rsp_dest !== e.dest) begin
						error_count++;
						$display("Fail at %0t: rsp_dest expected %0d got %0d", $time, e.dest, rsp_dest);
					end
					if (result !== e.result) begin
						error_count++;
						$display("Fail at %0t: result expected %0d got %0d", $time, e.result, result);
					end
					if (check_latency && (cycle - t0) != 3) begin
						error_count++;
						$display("Fail at %0t: latency expected 3 got %0d", $time, cycle - t0);
					end
				end
			end
			cycle++;
		end
	end

endmodule

/* tests/misc_alu_tb.sv */
`timescale 1ns/1ps

module misc_alu_tb
	import misc_alu_pkg::*;
();

	localparam int timeout_cycles = 200;
	localparam logic [31:0] seed = 32'h7b01490c;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	misc_op_t op;
	dest_t dest;
	logic sat_disable;
	shamt_t shamt;
	data_t a;
	data_t b;
	data_t c;
	acc_t acc;
	logic rsp_valid;
	logic rsp_ready;
	dest_t rsp_dest;
	acc_t result;

	logic [31:0] rng;
	logic [31:0] rdy_rng;
	logic ready_mode; // 0 holds rsp_ready high.
	logic check_latency;
	int other_errors;
	logic aborted;

	misc_alu u_misc_alu (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
		.op(op), .dest(dest), .sat_disable(sat_disable), .shamt(shamt),
		.a(a), .b(b), .c(c), .acc(acc), .rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready), .rsp_dest(rsp_dest), .result(result)
	);

	misc_alu_checker u_misc_alu_checker (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_dest(rsp_dest),
		.result(result), .check_latency(check_latency)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// expected result straight from the operation rules.
	function automatic acc_t model_result(logic [3:0] op_code, logic sat_off, shamt_t sh,
		data_t va, data_t vb, data_t vc, acc_t vacc);
		data_t v16;
		data_t lo;
		data_t hi;
		acc_t  r;
		v16 = '0;
		lo  = (vb < vc) ? vb : vc;
		hi  = (vb < vc) ? vc : vb;
		case (op_code)
			4'd0: v16 = va << sh;
			4'd1: v16 = $unsigned(va) >> sh;
			4'd2: v16 = (va < 0) ? -va : va;
			4'd3: v16 = (va < vb) ? va : vb;
			4'd4: v16 = (va > vb) ? va : vb;
			4'd5: v16 = (va < lo) ? lo : ((va > hi) ? hi : va);
			4'd7: v16 = vacc[31:16];
			4'd8: v16 = vacc[15:0];
			default: v16 = '0;
		endcase
		r = v16;
		if (op_code == 4'd6) begin
			r = vacc >>> 15;
		end
		if (!sat_off && r > 32767) begin
			r = 32767;
		end else if (!sat_off && r < -32768) begin
			r = -32768;
		end
		return r;
	endfunction

	task automatic send_req(input logic [3:0] op_code, input dest_t d, input logic sat,
		input shamt_t sh, input data_t va, input data_t vb, input data_t vc, input acc_t vacc);
		int   waited;
		logic go;
		if (aborted) begin
			return;
		end
		op          = misc_op_t'(op_code);
		dest        = d;
		sat_disable = sat;
		shamt       = sh;
		a           = va;
		b           = vb;
		c           = vc;
		acc         = vacc;
		req_valid   = 1'b1;
		u_misc_alu_checker.expect_rsp(d, model_result(op_code, sat, sh, va, vb, vc, vacc));
		waited = 0;
		go     = 1'b0;
		while (!go) begin
			@(negedge clk);
			go = req_ready;
			@(posedge clk);
			#1;
			waited++;
			if (!go && waited > timeout_cycles) begin
				other_errors++;
				aborted = 1'b1;
				$display("timeout: req_ready stayed low for %0d cycles", waited);
				return;
			end
		end
	endtask

	task automatic send_random(input int op_sel);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [3:0]  op_code;
		rng = xorshift(rng);
		r1  = rng;
		rng = xorshift(rng);
		r2  = rng;
		rng = xorshift(rng);
		r3  = rng;
		op_code = (op_sel < 0) ? r3[31:28] : op_sel[3:0];
		send_req(op_code, r3[3:0], r3[4], r3[11:8], r1[15:0], r1[31:16], r2[15:0],
			{r3[23:16], r2[31:16], r1[15:0]});
	endtask

	task automatic drain();
		int waited;
		waited    = 0;
		req_valid = 1'b0;
		while (!aborted && u_misc_alu_checker.pending_count() != 0) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > timeout_cycles) begin
				other_errors++;
				aborted = 1'b1;
				$display("timeout: %0d responses never came out",
					u_misc_alu_checker.pending_count());
				return;
			end
		end
	endtask

	task automatic check_idle();
		@(negedge clk);
		if (rsp_valid !== 1'b0) begin
			other_errors++;
			$display("Fail at %0t: rsp_valid expected 0 got %b", $time, rsp_valid);
		end
		if (req_ready !== 1'b1) begin
			other_errors++;
			$display("Fail at %0t: req_ready expected 1 got %b", $time, req_ready);
		end
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk) begin
		#1;
		rdy_rng   = xorshift(rdy_rng);
		rsp_ready = ready_mode ? (rdy_rng[9:8] != 2'b00) : 1'b1;
	end

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		req_valid     = 1'b0;
		op            = op_lsh;
		dest          = '0;
		sat_disable   = 1'b0;
		shamt         = '0;
		a             = '0;
		b             = '0;
		c             = '0;
		acc           = '0;
		rsp_ready     = 1'b1;
		ready_mode    = 1'b0;
		check_latency = 1'b0;
		other_errors  = 0;
		aborted       = 1'b0;
		rng           = seed;
		rdy_rng       = xorshift(~seed);
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		begin : run_tests
			int i;
			check_idle();
			ready_mode = 1'b1;
			send_req(4'd0, 4'd1, 1'b0, 4'd0, 16'sh1234, 16'sh0, 16'sh0, '0);
			send_req(4'd0, 4'd2, 1'b1, 4'd15, 16'sh0003, 16'sh0, 16'sh0, '0);
			send_req(4'd1, 4'd3, 1'b0, 4'd0, 16'sh8001, 16'sh0, 16'sh0, '0);
			send_req(4'd1, 4'd4, 1'b0, 4'd15, 16'sh8001, 16'sh0, 16'sh0, '0);
			send_req(4'd2, 4'd5, 1'b0, 4'd0, 16'sh8000, 16'sh0, 16'sh0, '0);
			send_req(4'd5, 4'd6, 1'b0, 4'd0, 16'sh0500, 16'sh0400, 16'sh0100, '0);
			send_req(4'd5, 4'd7, 1'b0, 4'd0, -16'sd900, 16'sh0400, -16'sd100, '0);
			// saturated and raw moves of large accumulators.
			send_req(4'd6, 4'd8, 1'b0, 4'd0, '0, '0, '0, 40'sh7f_ffff_ffff);
			send_req(4'd6, 4'd9, 1'b1, 4'd0, '0, '0, '0, 40'sh7f_ffff_ffff);
			send_req(4'd6, 4'd10, 1'b0, 4'd0, '0, '0, '0, 40'sh80_0000_0000);
			send_req(4'd6, 4'd11, 1'b1, 4'd0, '0, '0, '0, 40'sh80_0000_0000);
			for (i = 0; i < 300; i++) begin
				send_random(i % 9);
			end
			for (i = 9; i < 16; i++) begin
				send_random(i);
			end
			repeat (100) send_random(-1);
			drain();
			ready_mode = 1'b0;
			repeat (2) @(posedge clk);
			#1 check_latency = 1'b1;
			for (i = 0; i < 30; i++) begin
				send_random(i % 9);
			end
			drain();
			check_latency = 1'b0;
		end
		$display("errors: %0d compare, %0d other, %0d assertion, %0d responses checked",
			u_misc_alu_checker.error_count, other_errors,
			u_misc_alu.u_misc_alu_assert.fail_count, u_misc_alu_checker.checked_count);
		if (u_misc_alu_checker.error_count == 0 && other_errors == 0 &&
			u_misc_alu.u_misc_alu_assert.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
